// File: logic/probe_pkg.sv
package probe_pkg;

	// Event classes, also the lane index inside one channel
	typedef enum logic [1:0] {
		EV_HANDSHAKE,	// valid and ready
		EV_VALID,	// valid, ready ignored
		EV_READY,	// ready, valid ignored
		EV_EITHER	// valid or ready
	} ev_class_t;

	// Watched address channels
	typedef enum logic {
		CH_AW,
		CH_AR
	} ch_t;

	localparam int NUM_EV = 4;

	// Lane select is channel bit on top of the event class
	localparam int LANE_SEL_W = $bits(ch_t) + $bits(ev_class_t);

	typedef logic [LANE_SEL_W-1:0] lane_sel_t;

	function automatic lane_sel_t make_sel(ch_t ch, ev_class_t ev);
		return {ch, ev};
	endfunction

	function automatic ch_t sel_ch(lane_sel_t sel);
		return ch_t'(sel[LANE_SEL_W-1]);
	endfunction

	function automatic ev_class_t sel_ev(lane_sel_t sel);
		return ev_class_t'(sel[$bits(ev_class_t)-1:0]);
	endfunction

endpackage

// File: logic/capture_lane.sv
`timescale 1ns/1ps

module capture_lane #(
	parameter int ADDR_W = 32,
	parameter int DEPTH = 10,
	localparam int CNT_W = $clog2(DEPTH + 1),
	localparam int WR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input  logic                    clk,
	input  logic                    rst_x,
	input  logic                    i_event,
	input  logic [ADDR_W-1:0]       i_addr,
	output logic [DEPTH*ADDR_W-1:0] o_store,
	output logic [CNT_W-1:0]        o_count
);

	logic [CNT_W-1:0]  count;
	logic              full;
	logic              take;
	logic              pending;	// Staged address waiting for its slot
	logic [ADDR_W-1:0] stage;
	logic [WR_W-1:0]   wr_idx;
	logic [ADDR_W-1:0] store [DEPTH];

	assign full = (count == CNT_W'(DEPTH));
	assign take = i_event && !full;

	// Slot of the staged entry, count already moved past it
	assign wr_idx = WR_W'(count - 1'b1);

	always_ff @(posedge clk or negedge rst_x) begin
		if (!rst_x) begin
			count   <= '0;
			pending <= 1'b0;
		end
		else begin
			pending <= take;
			if (take) begin
				count <= count + 1'b1;	// Stops at DEPTH
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			stage <= i_addr;
		end
	end

	// Entries read zero until written
	always_ff @(posedge clk or negedge rst_x) begin
		if (!rst_x) begin
			for (int i = 0; i < DEPTH; i++) begin
				store[i] <= '0;
			end
		end
		else if (pending) begin
			store[wr_idx] <= stage;
		end
	end

	genvar g;
	generate
		for (g = 0; g < DEPTH; g++) begin : g_flat
			assign o_store[g*ADDR_W +: ADDR_W] = store[g];
		end
	endgenerate

	assign o_count = count;

endmodule

// File: logic/probe_channel.sv
`timescale 1ns/1ps

module probe_channel
	import probe_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DEPTH = 10,
	localparam int CNT_W = $clog2(DEPTH + 1),
	localparam int LANE_W = DEPTH * ADDR_W
) (
	input  logic                     clk,
	input  logic                     rst_x,
	input  logic                     i_valid,
	input  logic                     i_ready,
	input  logic [ADDR_W-1:0]        i_addr,
	output logic [NUM_EV*LANE_W-1:0] o_store,
	output logic [NUM_EV*CNT_W-1:0]  o_count
);

	logic [NUM_EV-1:0] ev;

	// One strobe per event class
	always_comb begin
		ev               = '0;
		ev[EV_HANDSHAKE] = i_valid & i_ready;
		ev[EV_VALID]     = i_valid;
		ev[EV_READY]     = i_ready;
		ev[EV_EITHER]    = i_valid | i_ready;
	end

	genvar g;
	generate
		for (g = 0; g < NUM_EV; g++) begin : g_lane
			capture_lane #(
				.ADDR_W (ADDR_W),
				.DEPTH  (DEPTH)
			) u_lane (
				.clk     (clk),
				.rst_x   (rst_x),
				.i_event (ev[g]),
				.i_addr  (i_addr),
				.o_store (o_store[g*LANE_W +: LANE_W]),
				.o_count (o_count[g*CNT_W +: CNT_W])
			);
		end
	endgenerate

endmodule

// File: logic/readout_mux.sv
`timescale 1ns/1ps

module readout_mux
	import probe_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DEPTH = 10,
	localparam int CNT_W = $clog2(DEPTH + 1),
	localparam int IDX_W = $clog2(DEPTH + 1),
	localparam int LANE_W = DEPTH * ADDR_W
) (
	input  logic                     clk,
	input  logic                     rst_x,
	input  logic [NUM_EV*LANE_W-1:0] i_aw_store,
	input  logic [NUM_EV*CNT_W-1:0]  i_aw_count,
	input  logic [NUM_EV*LANE_W-1:0] i_ar_store,
	input  logic [NUM_EV*CNT_W-1:0]  i_ar_count,
	input  lane_sel_t                i_rd_sel,
	input  logic [IDX_W-1:0]         i_rd_idx,
	output logic [ADDR_W-1:0]        o_rd_addr,
	output logic [CNT_W-1:0]         o_rd_count
);

	ch_t                     rd_ch;
	ev_class_t               rd_ev;
	logic [NUM_EV*LANE_W-1:0] chan_store;
	logic [NUM_EV*CNT_W-1:0]  chan_count;
	logic [LANE_W-1:0]        lane_store;
	logic [CNT_W-1:0]         lane_count;
	logic [ADDR_W-1:0]        entry;

	assign rd_ch = sel_ch(i_rd_sel);
	assign rd_ev = sel_ev(i_rd_sel);

	// Channel first
	always_comb begin
		chan_store = i_aw_store;
		chan_count = i_aw_count;
		if (rd_ch == CH_AR) begin
			chan_store = i_ar_store;
			chan_count = i_ar_count;
		end
	end

	// Then the lane of that channel
	always_comb begin
		lane_store = '0;
		lane_count = '0;
		for (int e = 0; e < NUM_EV; e++) begin
			if (ev_class_t'(e) == rd_ev) begin
				lane_store = chan_store[e*LANE_W +: LANE_W];
				lane_count = chan_count[e*CNT_W +: CNT_W];
			end
		end
	end

	// No match past DEPTH, so entry stays zero there
	always_comb begin
		entry = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (IDX_W'(i) == i_rd_idx) begin
				entry = lane_store[i*ADDR_W +: ADDR_W];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_x) begin
		if (!rst_x) begin
			o_rd_addr  <= '0;
			o_rd_count <= '0;
		end
		else begin
			o_rd_addr  <= entry;
			o_rd_count <= lane_count;	// Count of selected lane
		end
	end

endmodule

// File: logic/addr_probe_top.sv
`timescale 1ns/1ps

module addr_probe_top
	import probe_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DEPTH = 10,
	localparam int CNT_W = $clog2(DEPTH + 1),
	localparam int IDX_W = $clog2(DEPTH + 1),
	localparam int LANE_W = DEPTH * ADDR_W
) (
	input  logic              clk,
	input  logic              rst_x,

	// Write address channel, observed only
	input  logic              i_aw_valid,
	input  logic              i_aw_ready,
	input  logic [ADDR_W-1:0] i_aw_addr,

	// Read address channel, observed only
	input  logic              i_ar_valid,
	input  logic              i_ar_ready,
	input  logic [ADDR_W-1:0] i_ar_addr,

	// Readout request held as a level
	input  lane_sel_t         i_rd_sel,
	input  logic [IDX_W-1:0]  i_rd_idx,
	output logic [ADDR_W-1:0] o_rd_addr,
	output logic [CNT_W-1:0]  o_rd_count
);

	logic [NUM_EV*LANE_W-1:0] aw_store;
	logic [NUM_EV*CNT_W-1:0]  aw_count;
	logic [NUM_EV*LANE_W-1:0] ar_store;
	logic [NUM_EV*CNT_W-1:0]  ar_count;

	probe_channel #(
		.ADDR_W (ADDR_W),
		.DEPTH  (DEPTH)
	) aw_chan (
		.clk     (clk),
		.rst_x   (rst_x),
		.i_valid (i_aw_valid),
		.i_ready (i_aw_ready),
		.i_addr  (i_aw_addr),
		.o_store (aw_store),
		.o_count (aw_count)
	);

	probe_channel #(
		.ADDR_W (ADDR_W),
		.DEPTH  (DEPTH)
	) ar_chan (
		.clk     (clk),
		.rst_x   (rst_x),
		.i_valid (i_ar_valid),
		.i_ready (i_ar_ready),
		.i_addr  (i_ar_addr),
		.o_store (ar_store),
		.o_count (ar_count)
	);

	// One cycle behind the request
	readout_mux #(
		.ADDR_W (ADDR_W),
		.DEPTH  (DEPTH)
	) u_readout (
		.clk        (clk),
		.rst_x      (rst_x),
		.i_aw_store (aw_store),
		.i_aw_count (aw_count),
		.i_ar_store (ar_store),
		.i_ar_count (ar_count),
		.i_rd_sel   (i_rd_sel),
		.i_rd_idx   (i_rd_idx),
		.o_rd_addr  (o_rd_addr),
		.o_rd_count (o_rd_count)
	);

endmodule

// File: bench/probe_assert.sv
`timescale 1ns/1ps

module probe_assert
	import probe_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DEPTH = 10,
	localparam int CNT_W = $clog2(DEPTH + 1),
	localparam int IDX_W = $clog2(DEPTH + 1)
) (
	input logic                    clk,
	input logic                    rst_x,
	input logic [NUM_EV*CNT_W-1:0] i_aw_count,
	input logic [NUM_EV*CNT_W-1:0] i_ar_count,
	input logic [IDX_W-1:0]        i_rd_idx,
	input logic [ADDR_W-1:0]       i_rd_addr,
	input logic [CNT_W-1:0]        i_rd_count
);

	function automatic logic counts_in_range(logic [NUM_EV*CNT_W-1:0] counts);
		logic ok;
		ok = 1'b1;
		for (int e = 0; e < NUM_EV; e++) begin
			if (counts[e*CNT_W +: CNT_W] > CNT_W'(DEPTH)) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	aw_count_bound: assert property (@(posedge clk) disable iff (!rst_x)
		counts_in_range(i_aw_count))
		else $error("write channel lane count above DEPTH");

	ar_count_bound: assert property (@(posedge clk) disable iff (!rst_x)
		counts_in_range(i_ar_count))
		else $error("read channel lane count above DEPTH");

	rd_count_bound: assert property (@(posedge clk) disable iff (!rst_x)
		i_rd_count <= CNT_W'(DEPTH))
		else $error("readout count above DEPTH");

	// Index past the store reads zero on the next cycle
	idx_past_depth: assert property (@(posedge clk) disable iff (!rst_x)
		(i_rd_idx >= IDX_W'(DEPTH)) |=> (i_rd_addr == '0))
		else $error("readout beyond DEPTH returned a nonzero address");

endmodule

bind readout_mux probe_assert #(
	.ADDR_W (ADDR_W),
	.DEPTH  (DEPTH)
) u_probe_assert (
	.clk        (clk),
	.rst_x      (rst_x),
	.i_aw_count (i_aw_count),
	.i_ar_count (i_ar_count),
	.i_rd_idx   (i_rd_idx),
	.i_rd_addr  (o_rd_addr),
	.i_rd_count (o_rd_count)
);

// File: bench/probe_checker.sv
`timescale 1ns/1ps

module probe_checker
	import probe_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DEPTH = 10,
	parameter int EXP_CHECKS = 0,
	localparam int CNT_W = $clog2(DEPTH + 1),
	localparam int IDX_W = $clog2(DEPTH + 1),
	localparam int NUM_LANES = 2 * NUM_EV
) (
	input  logic              clk,
	input  logic              rst_x,
	input  logic              i_aw_valid,
	input  logic              i_aw_ready,
	input  logic [ADDR_W-1:0] i_aw_addr,
	input  logic              i_ar_valid,
	input  logic              i_ar_ready,
	input  logic [ADDR_W-1:0] i_ar_addr,
	input  lane_sel_t         i_rd_sel,
	input  logic [IDX_W-1:0]  i_rd_idx,
	input  logic [ADDR_W-1:0] i_rd_addr,
	input  logic [CNT_W-1:0]  i_rd_count,
	input  logic              i_check,	// Readout sweep running
	input  logic              i_done,
	output int                o_errors
);

	logic [ADDR_W-1:0] model_addr [NUM_LANES][DEPTH];
	int                model_cnt [NUM_LANES];
	int                checks;
	logic              prev_check;
	lane_sel_t         prev_sel;
	logic [IDX_W-1:0]  prev_idx;
	logic              reported;

	// Event class rule for one sampled cycle
	function automatic logic is_event(ev_class_t ev, logic valid, logic ready);
		case (ev)
			EV_HANDSHAKE: return valid && ready;
			EV_VALID:     return valid;
			EV_READY:     return ready;
			default:      return valid || ready;
		endcase
	endfunction

	function automatic logic [ADDR_W-1:0] expected_addr(int lane, int idx);
		if (idx < model_cnt[lane]) begin
			return model_addr[lane][idx];
		end
		return '0;	// Unwritten or past DEPTH
	endfunction

	task automatic record_cycle(int ch, logic valid, logic ready, logic [ADDR_W-1:0] addr);
		int lane;
		for (int e = 0; e < NUM_EV; e++) begin
			lane = ch * NUM_EV + e;
			if (is_event(ev_class_t'(e), valid, ready) && model_cnt[lane] < DEPTH) begin
				model_addr[lane][model_cnt[lane]] = addr;
				model_cnt[lane]++;
			end
		end
	endtask

	task automatic compare_readout();
		int                lane;
		logic [ADDR_W-1:0] exp_addr;
		logic [CNT_W-1:0]  exp_cnt;
		lane     = int'(prev_sel);
		exp_addr = expected_addr(lane, int'(prev_idx));
		exp_cnt  = CNT_W'(model_cnt[lane]);
		checks++;
		if (i_rd_addr !== exp_addr) begin
			$display("mismatch at %0t: o_rd_addr got 0x%h, expected 0x%h (lane %0d, index %0d)",
				$time, i_rd_addr, exp_addr, lane, prev_idx);
			o_errors++;
		end
		if (i_rd_count !== exp_cnt) begin
			$display("mismatch at %0t: o_rd_count got %0d, expected %0d (lane %0d)",
				$time, i_rd_count, exp_cnt, lane);
			o_errors++;
		end
	endtask

	// Compare first, then fold this cycle into the model
	always @(posedge clk or negedge rst_x) begin
		if (!rst_x) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				model_cnt[l] = 0;
				for (int i = 0; i < DEPTH; i++) begin
					model_addr[l][i] = '0;
				end
			end
			checks     = 0;
			o_errors   = 0;
			prev_check = 1'b0;
			prev_sel   = '0;
			prev_idx   = '0;
			reported   = 1'b0;
		end
		else begin
			if (prev_check) begin
				compare_readout();
			end
			record_cycle(0, i_aw_valid, i_aw_ready, i_aw_addr);
			record_cycle(1, i_ar_valid, i_ar_ready, i_ar_addr);
			prev_check = i_check;
			prev_sel   = i_rd_sel;
			prev_idx   = i_rd_idx;
			if (i_done && !reported) begin
				if (checks != EXP_CHECKS) begin
					$display("error: %0d readout checks ran where %0d were expected",
						checks, EXP_CHECKS);
					o_errors++;
				end
				$display("checker: %0d readout checks, %0d errors", checks, o_errors);
				reported = 1'b1;
			end
		end
	end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top
	import probe_pkg::*;
;

	localparam int ADDR_W = 32;
	localparam int DEPTH = 10;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int IDX_W = $clog2(DEPTH + 1);
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DLY = 2;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 4;
	localparam int BURST_CYCLES = DEPTH / 2;	// Half a lane so random traffic fills the rest
	localparam int RANDOM_CYCLES = 600;
	localparam int SWEEP_REQS = 2 * NUM_EV * (DEPTH + 1);
	localparam int EXP_CHECKS = 2 * SWEEP_REQS;
	localparam int RUN_CYCLES = RESET_CYCLES + 2 * (IDLE_CYCLES + SWEEP_REQS + 2)
		+ BURST_CYCLES + RANDOM_CYCLES + 2;
	localparam int MARGIN_CYCLES = 200;

	logic              clk;
	logic              rst_x;
	logic              aw_valid;
	logic              aw_ready;
	logic [ADDR_W-1:0] aw_addr;
	logic              ar_valid;
	logic              ar_ready;
	logic [ADDR_W-1:0] ar_addr;
	lane_sel_t         rd_sel;
	logic [IDX_W-1:0]  rd_idx;
	logic [ADDR_W-1:0] rd_addr;
	logic [CNT_W-1:0]  rd_count;
	logic              check_en;
	logic              run_done;
	int                errors;

	addr_probe_top #(
		.ADDR_W (ADDR_W),
		.DEPTH  (DEPTH)
	) dut (
		.clk        (clk),
		.rst_x      (rst_x),
		.i_aw_valid (aw_valid),
		.i_aw_ready (aw_ready),
		.i_aw_addr  (aw_addr),
		.i_ar_valid (ar_valid),
		.i_ar_ready (ar_ready),
		.i_ar_addr  (ar_addr),
		.i_rd_sel   (rd_sel),
		.i_rd_idx   (rd_idx),
		.o_rd_addr  (rd_addr),
		.o_rd_count (rd_count)
	);

	probe_checker #(
		.ADDR_W     (ADDR_W),
		.DEPTH      (DEPTH),
		.EXP_CHECKS (EXP_CHECKS)
	) u_check (
		.clk        (clk),
		.rst_x      (rst_x),
		.i_aw_valid (aw_valid),
		.i_aw_ready (aw_ready),
		.i_aw_addr  (aw_addr),
		.i_ar_valid (ar_valid),
		.i_ar_ready (ar_ready),
		.i_ar_addr  (ar_addr),
		.i_rd_sel   (rd_sel),
		.i_rd_idx   (rd_idx),
		.i_rd_addr  (rd_addr),
		.i_rd_count (rd_count),
		.i_check    (check_en),
		.i_done     (run_done),
		.o_errors   (errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic advance();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	function automatic logic rand_bit(int unsigned pct);
		return $urandom_range(99, 0) < pct;
	endfunction

	task automatic idle_bus(int cycles);
		aw_valid = 1'b0;
		aw_ready = 1'b0;
		ar_valid = 1'b0;
		ar_ready = 1'b0;
		repeat (cycles) advance();
	endtask

	// Back-to-back write handshakes fire all four AW lanes
	task automatic handshake_burst(int cycles);
		for (int i = 0; i < cycles; i++) begin
			aw_valid = 1'b1;
			aw_ready = 1'b1;
			aw_addr  = 32'h1000_0000 + ADDR_W'(i * 4);
			advance();
		end
	endtask

	task automatic random_traffic(int cycles);
		repeat (cycles) begin
			aw_valid = rand_bit(30);
			aw_ready = rand_bit(30);
			aw_addr  = ADDR_W'($urandom());
			ar_valid = rand_bit(25);
			ar_ready = rand_bit(35);
			ar_addr  = ADDR_W'($urandom());
			advance();
		end
	endtask

	// Every lane, every index up to DEPTH, a new request each cycle
	task automatic sweep_readout();
		check_en = 1'b1;
		for (int s = 0; s < 2 * NUM_EV; s++) begin
			for (int i = 0; i <= DEPTH; i++) begin
				rd_sel = lane_sel_t'(s);
				rd_idx = IDX_W'(i);
				advance();
			end
		end
		check_en = 1'b0;
		rd_sel   = '0;
		rd_idx   = '0;
		advance();
		advance();
	endtask

	initial begin
		void'($urandom(32'h9bf8));
		rst_x    = 1'b0;
		aw_valid = 1'b0;
		aw_ready = 1'b0;
		aw_addr  = '0;
		ar_valid = 1'b0;
		ar_ready = 1'b0;
		ar_addr  = '0;
		rd_sel   = '0;
		rd_idx   = '0;
		check_en = 1'b0;
		run_done = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_x = 1'b1;
		idle_bus(IDLE_CYCLES);
		sweep_readout();	// All zero after reset
		handshake_burst(BURST_CYCLES);
		random_traffic(RANDOM_CYCLES);
		idle_bus(IDLE_CYCLES);
		sweep_readout();
		run_done = 1'b1;
		advance();
		advance();
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end
		else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
		$display("timeout: the run did not finish within %0d cycles",
			RUN_CYCLES + MARGIN_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim.f
logic/probe_pkg.sv
logic/capture_lane.sv
logic/probe_channel.sv
logic/readout_mux.sv
logic/addr_probe_top.sv
bench/probe_assert.sv
bench/probe_checker.sv
bench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(shell grep -E '\.s?v$$' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
